// ==== bench/linkTb.sv ====
module linkTb
  import nocPkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int packetsPerPort = 12;
  localparam int maskedPort     = 2;

  logic                                clk;
  logic                                rst;
  logic [portCount-1:0]                inValid;
  logic [portCount-1:0][flitWidth-1:0] inFlit;
  logic [portCount-1:0]                inReady;
  logic                                outValid;
  logic [flitWidth-1:0]                outFlit;
  logic [portIdxWidth-1:0]             outPort;
  logic                                outReady;
  logic [addrWidth-1:0]                paddr;
  logic                                psel;
  logic                                penable;
  logic                                pwrite;
  logic [31:0]                         pwdata;
  logic [31:0]                         prdata;
  logic                                pready;
  logic                                pslverr;

  // per port queues of flits still to send and of accepted flits.
  logic [flitWidth-1:0]    stimQ [portCount][$];
  logic [flitWidth-1:0]    modelQ [portCount][$];
  int                      sendIdx [portCount];
  int                      modelCount [portCount];
  int                      headLimit [portCount];
  int                      runPort;
  int                      runLen;
  bit                      contested;
  bit                      holdCheck;
  logic [portCount-1:0]    took;
  int                      errors;
  int                      cycles;
  int                      totalFlits;
  bit                      running;
  bit                      masked;
  int                      maskGrace;
  logic                    stallSeen;
  logic [flitWidth-1:0]    stallFlit;
  logic [portIdxWidth-1:0] stallPort;

  nocLinkTop #(
    .fifoDepth (4)
  ) nocLinkTop_i (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .inReady  (inReady),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort),
    .outReady (outReady),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ======================================================================
  // checks and reporting
  // ======================================================================
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (expected == actual)
    else
    begin
      errors++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    assert (cond)
    else
    begin
      errors++;
      $display("error: %s", what);
    end
  endtask

  task automatic finishRun();
    $display("%0d errors after %0d cycles", errors, cycles);
    if (errors == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  endtask

  // header carries the length, bodies carry port, packet and flit number.
  task automatic addPacket(input int p, input int seq, input int len);
    flitT f;
    f           = '0;
    f.head.id     = headId;
    f.head.length = lengthWidth'(len);
    stimQ[p].push_back(f);
    for (int k = 1; k < len; k++)
    begin
      f              = '0;
      f.body.id      = (k == len - 1) ? 3'd3 : 3'd2;
      f.body.payload = {3'(p), 6'(seq), 4'(k)};
      stimQ[p].push_back(f);
    end
    totalFlits += len;
  endtask

  task automatic apbAccess(input logic write, input logic [addrWidth-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
    int waited;
    waited = 0;
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready && waited < 16)
    begin
      waited++;
      @(posedge clk);
    end
    checkTrue(pready, "APB access never saw pready");
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  function automatic logic [addrWidth-1:0] countAddr(input int p);
    return addrWidth'(regCountBase + 4 * p);
  endfunction

  function automatic bit allDrained();
    bit done;
    done = 1'b1;
    for (int p = 0; p < portCount; p++)
    begin
      if (sendIdx[p] != stimQ[p].size() || modelQ[p].size() != 0)
      begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // one forwarded flit against the model.
  task automatic forwardFlit();
    int   p;
    flitT f;
    p = int'(outPort);
    f = outFlit;
    if (p >= portCount)
    begin
      checkTrue(1'b0, "outPort names no input port");
      return;
    end
    if (modelQ[p].size() == 0)
    begin
      checkTrue(1'b0, "a flit left the link that was never accepted");
      return;
    end
    checkValue("ordering", modelQ[p][0], outFlit);
    void'(modelQ[p].pop_front());
    modelCount[p]++;
    // a run only grows while another enabled port was waiting.
    if (p == runPort && contested)
    begin
      runLen++;
    end
    else
    begin
      runLen = 1;
    end
    runPort = p;
    if (f.head.id == headId)
    begin
      headLimit[p] = int'(f.head.length);
    end
    if (holdCheck)
    begin
      checkTrue(runLen <= headLimit[p],
                "a contested grant forwarded more flits than its header length");
    end
    // queues of the other ports hold exactly what their FIFOs hold now.
    contested = 1'b0;
    for (int q = 0; q < portCount; q++)
    begin
      if (q != p && modelQ[q].size() != 0)
      begin
        contested = holdCheck;
      end
    end
    // the flit already granted at the write edge may still pass.
    if (masked && p == maskedPort)
    begin
      if (maskGrace > 0)
      begin
        maskGrace--;
      end
      else
      begin
        checkTrue(1'b0, "a disabled port forwarded a flit");
      end
    end
  endtask

  // ======================================================================
  // monitor and stimulus
  // ======================================================================
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (stallSeen)
      begin
        checkTrue(outValid, "outValid dropped while outReady was low");
        checkValue("stall flit", stallFlit, outFlit);
        checkValue("stall port", 32'(stallPort), 32'(outPort));
      end
      if (outValid && outReady)
      begin
        forwardFlit();
      end
      stallSeen = outValid && !outReady;
      stallFlit = outFlit;
      stallPort = outPort;
      for (int p = 0; p < portCount; p++)
      begin
        if (inValid[p] && inReady[p])
        begin
          modelQ[p].push_back(inFlit[p]);
          sendIdx[p]++;
          took[p] = 1'b1;
        end
      end
    end
  end

  // valid stays up until the flit is taken.
  always @(negedge clk)
  begin
    if (running)
    begin
      for (int p = 0; p < portCount; p++)
      begin
        if (!inValid[p] || took[p])
        begin
          if (sendIdx[p] < stimQ[p].size() && ($urandom % 4) != 0)
          begin
            inValid[p] = 1'b1;
            inFlit[p]  = stimQ[p][sendIdx[p]];
          end
          else
          begin
            inValid[p] = 1'b0;
          end
        end
        took[p] = 1'b0;
      end
      outReady = ($urandom % 10) < 7;
    end
  end

  initial
  begin
    while (cycles < 20 * totalFlits + 2000)
    begin
      @(posedge clk);
      cycles++;
    end
    checkTrue(1'b0, "run did not finish within the cycle limit");
    finishRun();
  end

  initial
  begin
    logic [31:0] rdata;
    logic        err;
    void'($urandom(32'h56ec));
    errors     = 0;
    cycles     = 0;
    totalFlits = 0;
    running    = 1'b0;
    masked     = 1'b0;
    maskGrace  = 0;
    runPort    = -1;
    runLen     = 0;
    contested  = 1'b0;
    holdCheck  = 1'b1;
    stallSeen  = 1'b0;
    stallFlit  = '0;
    stallPort  = '0;
    took       = '0;
    rst        = 1'b1;
    inValid    = '0;
    inFlit     = '0;
    outReady   = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    for (int p = 0; p < portCount; p++)
    begin
      sendIdx[p]    = 0;
      modelCount[p] = 0;
      headLimit[p]  = 0;
      for (int k = 0; k < packetsPerPort; k++)
      begin
        addPacket(p, k, 1 + int'($urandom % 6));
      end
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;

    @(negedge clk);
    checkValue("reset outValid", 32'h0, 32'(outValid));
    checkValue("reset inReady", 32'h1f, 32'(inReady));
    apbAccess(1'b0, regEnable, 32'h0, rdata, err);
    checkValue("reset enable", 32'h1f, rdata);
    for (int p = 0; p < portCount; p++)
    begin
      apbAccess(1'b0, countAddr(p), 32'h0, rdata, err);
      checkValue("reset counter", 32'h0, rdata);
    end

    @(posedge clk);
    running = 1'b1;
    repeat (120) @(negedge clk);

    // take East off the link for a while.
    holdCheck = 1'b0;
    apbAccess(1'b1, regEnable, 32'h1f & ~(32'h1 << maskedPort), rdata, err);
    checkValue("enable write error", 32'h0, 32'(err));
    masked    = 1'b1;
    maskGrace = 1;
    repeat (80) @(negedge clk);
    masked = 1'b0;
    apbAccess(1'b1, regEnable, 32'h1f, rdata, err);
    holdCheck = 1'b1;

    while (!allDrained())
    begin
      @(negedge clk);
    end

    for (int p = 0; p < portCount; p++)
    begin
      apbAccess(1'b0, countAddr(p), 32'h0, rdata, err);
      checkValue("forwarded counter", 32'(modelCount[p] % 65536), rdata);
    end
    apbAccess(1'b1, countAddr(1), 32'h1, rdata, err);
    checkValue("counter write error", 32'h1, 32'(err));
    apbAccess(1'b0, 5'h18, 32'h0, rdata, err);
    checkValue("unmapped read error", 32'h1, 32'(err));
    finishRun();
  end

endmodule

// ==== hw/flitInput.sv ====
module flitInput
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   inValid,
  input  logic [flitWidth-1:0]   inFlit,
  output logic                   inReady,
  input  logic                   pop,
  output logic                   req,
  output flitT                   headFlit,
  output logic                   isHead,
  output logic [lengthWidth-1:0] headLength
);

  localparam int ptrWidth = $clog2(fifoDepth);
  localparam logic [ptrWidth:0] fullLevel = (ptrWidth + 1)'(fifoDepth);

  flitT                mem [fifoDepth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0]   used;
  logic                push;
  logic                take;

  assign inReady = (used != fullLevel);
  assign push    = inValid & inReady;
  assign take    = pop & req;

  // flit storage.
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  // pointers wrap on their own, depth is a power of two.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      used  <= '0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (take)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, take})
        2'b10:
        begin
          used <= used + 1'b1;
        end
        2'b01:
        begin
          used <= used - 1'b1;
        end
        default:
        begin
          used <= used;
        end
      endcase
    end
  end

  // ======================================================================
  // head of queue
  // ======================================================================
  assign req      = (used != '0);
  assign headFlit = mem[rdPtr];

  // decoded through the header view.
  assign isHead     = (headFlit.head.id == headId);
  assign headLength = headFlit.head.length;

endmodule

// ==== hw/holdTimer.sv ====
module holdTimer
  import nocPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  logic [lengthWidth-1:0] length,
  input  logic                   step,
  input  logic                   held,
  output logic                   spent
);

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] count;
  logic [lengthWidth-1:0] nextCount;
  logic [lengthWidth-1:0] nextLimit;

  // a header always opens a new run of flits.
  assign nextCount = load ? lengthWidth'(1) : count + 1'b1;
  assign nextLimit = load ? length : limit;

  // looks ahead at the flit leaving this cycle so the grant ends in time.
  assign spent = step ? (nextCount == nextLimit) : (count == limit);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '1;
      count <= '0;
    end
    else
    begin
      limit <= nextLimit;
      if (!held)
      begin
        count <= '0;
      end
      else if (step)
      begin
        count <= nextCount;
      end
    end
  end

endmodule

// ==== hw/linkArbiter.sv ====
module linkArbiter
  import nocPkg::*;
(
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [portCount-1:0]                  req,
  input  logic [portCount-1:0]                  portEnable,
  input  logic [portCount-1:0]                  isHead,
  input  logic [portCount-1:0]                  fire,
  input  logic                                  stall,
  input  logic [portCount-1:0][lengthWidth-1:0] headLength,
  output logic [portCount-1:0]                  grant
);

  // bit 0 is idle, bit p+1 means port p owns the link.
  localparam logic [portCount:0] idleState = 1;

  logic [portCount:0]   state;
  logic [portCount:0]   nextState;
  logic [portCount-1:0] spent;
  logic [portCount-1:0] eligible;
  logic [portCount-1:0] keep;
  logic                 hasSent;

  assign grant    = state[portCount:1];
  assign eligible = req & portEnable;

  // the owner keeps the link until its budget or its packet ends.
  assign keep = grant & eligible & ~spent & ~(isHead & {portCount{hasSent}});

  for (genvar p = 0; p < portCount; p++)
  begin : timerGen
    holdTimer holdTimer_i (
      .clk    (clk),
      .rst    (rst),
      .load   (fire[p] & isHead[p]),
      .length (headLength[p]),
      .step   (fire[p]),
      .held   (grant[p]),
      .spent  (spent[p])
    );
  end

  // ======================================================================
  // rotating priority
  // ======================================================================
  always_comb
  begin
    int   current;
    int   cand;
    logic found;
    current   = 0;
    cand      = 0;
    found     = 1'b0;
    nextState = state;
    // search starts just after the owner, idle starts at Local.
    for (int p = 0; p < portCount; p++)
    begin
      if (grant[p])
      begin
        current = p + 1;
      end
    end
    if (!stall && !(|keep))
    begin
      nextState = idleState;
      for (int k = 0; k < portCount; k++)
      begin
        cand = current + k;
        if (cand >= portCount)
        begin
          cand = cand - portCount;
        end
        if (!found && eligible[cand])
        begin
          nextState           = '0;
          nextState[cand + 1] = 1'b1;
          found               = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= idleState;
      hasSent <= 1'b0;
    end
    else
    begin
      state <= nextState;
      // set once the current hold has moved a flit.
      if (!stall)
      begin
        hasSent <= (|keep) & (hasSent | (|fire));
      end
    end
  end

endmodule

// ==== hw/linkOutput.sv ====
module linkOutput
  import nocPkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [portCount-1:0]                 grant,
  input  logic [portCount-1:0]                 req,
  input  flitT [portCount-1:0]                 headFlit,
  output logic                                 outValid,
  output logic [flitWidth-1:0]                 outFlit,
  output logic [portIdxWidth-1:0]              outPort,
  input  logic                                 outReady,
  output logic [portCount-1:0]                 pop,
  output logic                                 stall,
  output logic [portCount-1:0][countWidth-1:0] flitCount
);

  logic [portCount-1:0] active;
  logic                 fire;

  assign active   = grant & req;
  assign outValid = |active;
  assign fire     = outValid & outReady;
  assign stall    = outValid & ~outReady;
  assign pop      = fire ? active : '0;

  // ======================================================================
  // output mux and source tag
  // ======================================================================
  always_comb
  begin
    outFlit = '0;
    outPort = '0;
    for (int p = 0; p < portCount; p++)
    begin
      if (grant[p])
      begin
        outFlit = headFlit[p];
        outPort = portIdxWidth'(p);
      end
    end
  end

  // forwarded flits per port, wrapping.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flitCount <= '0;
    end
    else
    begin
      for (int p = 0; p < portCount; p++)
      begin
        if (pop[p])
        begin
          flitCount[p] <= flitCount[p] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== hw/linkRegs.sv ====
module linkRegs
  import nocPkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [addrWidth-1:0]                 paddr,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [31:0]                          pwdata,
  output logic [31:0]                          prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  input  logic [portCount-1:0][countWidth-1:0] flitCount,
  output logic [portCount-1:0]                 portEnable
);

  logic                    access;
  logic [addrWidth-1:0]    countOff;
  logic [portIdxWidth-1:0] countIdx;
  logic                    isEnable;
  logic                    isCount;
  logic                    mapped;

  // no wait states.
  assign access = psel & penable;
  assign pready = access;

  // ======================================================================
  // address decode
  // ======================================================================
  assign countOff = paddr - regCountBase;
  assign countIdx = countOff[addrWidth-1:2];
  assign isEnable = (paddr == regEnable);
  assign isCount  = (paddr >= regCountBase) && (countOff[1:0] == 2'b00)
                    && (countIdx < portCount);
  assign mapped   = isEnable | isCount;

  // counters are read-only.
  assign pslverr = access & (~mapped | (isCount & pwrite));

  always_comb
  begin
    prdata = '0;
    if (access && !pwrite)
    begin
      if (isEnable)
      begin
        prdata[portCount-1:0] = portEnable;
      end
      else if (isCount)
      begin
        prdata[countWidth-1:0] = flitCount[countIdx];
      end
    end
  end

  // all ports start enabled.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      portEnable <= '1;
    end
    else if (access && pwrite && isEnable)
    begin
      portEnable <= pwdata[portCount-1:0];
    end
  end

endmodule

// ==== hw/nocLinkTop.sv ====
module nocLinkTop
  import nocPkg::*;
#(
  parameter int fifoDepth = 4
)
(
  input  logic                                clk,
  input  logic                                rst,
  input  logic [portCount-1:0]                inValid,
  input  logic [portCount-1:0][flitWidth-1:0] inFlit,
  output logic [portCount-1:0]                inReady,
  output logic                                outValid,
  output logic [flitWidth-1:0]                outFlit,
  output logic [portIdxWidth-1:0]             outPort,
  input  logic                                outReady,
  input  logic [addrWidth-1:0]                paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr
);

  logic [portCount-1:0]                  req;
  logic [portCount-1:0]                  isHead;
  logic [portCount-1:0][lengthWidth-1:0] headLength;
  flitT [portCount-1:0]                  headFlit;
  logic [portCount-1:0]                  grant;
  logic [portCount-1:0]                  pop;
  logic                                  stall;
  logic [portCount-1:0][countWidth-1:0]  flitCount;
  logic [portCount-1:0]                  portEnable;

  // ======================================================================
  // input side
  // ======================================================================
  for (genvar p = 0; p < portCount; p++)
  begin : inputGen
    flitInput #(
      .fifoDepth (fifoDepth)
    ) flitInput_i (
      .clk        (clk),
      .rst        (rst),
      .inValid    (inValid[p]),
      .inFlit     (inFlit[p]),
      .inReady    (inReady[p]),
      .pop        (pop[p]),
      .req        (req[p]),
      .headFlit   (headFlit[p]),
      .isHead     (isHead[p]),
      .headLength (headLength[p])
    );
  end

  linkArbiter linkArbiter_i (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .portEnable (portEnable),
    .isHead     (isHead),
    .fire       (pop),
    .stall      (stall),
    .headLength (headLength),
    .grant      (grant)
  );

  // ======================================================================
  // output side
  // ======================================================================
  linkOutput linkOutput_i (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .req       (req),
    .headFlit  (headFlit),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .outPort   (outPort),
    .outReady  (outReady),
    .pop       (pop),
    .stall     (stall),
    .flitCount (flitCount)
  );

  linkRegs linkRegs_i (
    .clk        (clk),
    .rst        (rst),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .flitCount  (flitCount),
    .portEnable (portEnable)
  );

endmodule

// ==== hw/nocPkg.sv ====
package nocPkg;

  // ======================================================================
  // link geometry
  // ======================================================================

  // ports in order Local, North, East, West, South.
  localparam int portCount    = 5;
  localparam int portIdxWidth = $clog2(portCount);
  localparam int flitWidth    = 16;
  localparam int idWidth      = 3;
  localparam int lengthWidth  = 12;
  localparam int payloadWidth = flitWidth - idWidth;
  localparam int countWidth   = 16;

  // any other id is a body or tail flit.
  localparam logic [idWidth-1:0] headId = 3'd1;

  // ======================================================================
  // apb register map
  // ======================================================================
  localparam int addrWidth = 5;

  localparam logic [addrWidth-1:0] regEnable    = 5'h00;
  localparam logic [addrWidth-1:0] regCountBase = 5'h04;

  // one flit word, seen as header or as body.
  typedef union packed {
    struct packed {
      logic [idWidth-1:0]     id;
      logic [lengthWidth-1:0] length;
      logic                   spare;
    } head;
    struct packed {
      logic [idWidth-1:0]      id;
      logic [payloadWidth-1:0] payload;
    } body;
  } flitT;

endpackage

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module linkTb -f src.f -o linkSim

./obj_dir/linkSim | tee sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0

// ==== src.f ====
hw/nocPkg.sv
hw/flitInput.sv
hw/holdTimer.sv
hw/linkArbiter.sv
hw/linkOutput.sv
hw/linkRegs.sv
hw/nocLinkTop.sv
bench/linkTb.sv
